// File: src/core_pkg.sv
package core_pkg;

    localparam int WORD_W    = 16;
    localparam int REG_IDX_W = 3;
    localparam int NUM_REGS  = 8;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [WORD_W-1:0]    instr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    localparam word_t RESET_PC = 16'h0000; // first fetch address.

    // opcode sits in instruction bits 15..12.
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_ADDI = 4'd5,
        OP_LUI  = 4'd6,
        OP_LW   = 4'd7,
        OP_SW   = 4'd8,
        OP_BEQ  = 4'd9,
        OP_BNE  = 4'd10,
        OP_JAL  = 4'd11,
        OP_HALT = 4'd12
    } opcode_t;

    typedef struct packed {
        instr_t instr;
        word_t  pc;
    } fetch_pkt_t;

    typedef struct packed {
        opcode_t  op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    imm;   // already sign-extended or shifted.
        word_t    pc;
        logic     wr_en;
    } uop_t;

    typedef struct packed {
        logic  write;
        word_t addr;
        word_t wdata;
    } dmem_req_t;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_RSP,
        DROP_RSP
    } fetch_state_t;

    typedef enum logic [1:0] {
        RUN,
        WAIT_LOAD,
        HALTED
    } exec_state_t;

endpackage : core_pkg

// File: src/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  core_pkg::reg_idx_t rs1_idx_i,
    input  core_pkg::reg_idx_t rs2_idx_i,
    output core_pkg::word_t    rs1_data_o,
    output core_pkg::word_t    rs2_data_o,
    input  logic               wr_en_i,
    input  core_pkg::reg_idx_t wr_idx_i,
    input  core_pkg::word_t    wr_data_i
);
    import core_pkg::*;

    word_t regs_q [NUM_REGS];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) regs_q[i] <= '0;
        end else if (wr_en_i && wr_idx_i != '0) begin
            regs_q[wr_idx_i] <= wr_data_i; // entry 0 never written, so it reads zero.
        end
    end

    assign rs1_data_o = regs_q[rs1_idx_i];
    assign rs2_data_o = regs_q[rs2_idx_i];

endmodule : register_file

// File: src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    output logic                 imem_req_valid_o,
    input  logic                 imem_req_ready_i,
    output core_pkg::word_t      imem_req_addr_o,
    input  logic                 imem_rsp_valid_i,
    input  core_pkg::instr_t     imem_rsp_instr_i,
    output logic                 pkt_valid_o,
    input  logic                 pkt_ready_i,
    output core_pkg::fetch_pkt_t pkt_o,
    input  logic                 redirect_valid_i,
    input  core_pkg::word_t      redirect_pc_i,
    input  logic                 halted_i
);
    import core_pkg::*;

    fetch_state_t state_q;
    word_t        pc_q;        // address of the pending or outstanding request.
    word_t        redir_pc_q;
    logic         redir_q;     // redirect seen while a request was still waiting.
    logic         buf_valid_q;
    fetch_pkt_t   buf_q;
    logic         req_fire;

    // buffer is empty or drains this cycle, and stays empty until our response.
    assign imem_req_valid_o = rst_n_i && (state_q == IDLE) && !halted_i &&
                              (!buf_valid_q || pkt_ready_i);
    assign imem_req_addr_o  = pc_q;
    assign req_fire         = imem_req_valid_o && imem_req_ready_i;

    assign pkt_valid_o = buf_valid_q;
    assign pkt_o       = buf_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            pc_q        <= RESET_PC;
            redir_q     <= 1'b0;
            buf_valid_q <= 1'b0;
        end else begin
            if (buf_valid_q && pkt_ready_i) buf_valid_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (req_fire) begin
                        if (redir_q || redirect_valid_i) begin
                            state_q <= DROP_RSP; // request went out on the old path.
                            pc_q    <= redir_q ? redir_pc_q : redirect_pc_i;
                        end else begin
                            state_q <= WAIT_RSP;
                        end
                        redir_q <= 1'b0;
                    end else if (redirect_valid_i) begin
                        if (imem_req_valid_o) redir_q <= 1'b1; // keep address stable.
                        else pc_q <= redirect_pc_i;
                    end
                end
                WAIT_RSP: begin
                    if (imem_rsp_valid_i) begin
                        state_q <= IDLE;
                        if (redirect_valid_i) begin
                            pc_q <= redirect_pc_i;
                        end else begin
                            pc_q        <= pc_q + 16'd1;
                            buf_valid_q <= 1'b1;
                        end
                    end else if (redirect_valid_i) begin
                        state_q <= DROP_RSP;
                        pc_q    <= redirect_pc_i;
                    end
                end
                DROP_RSP: begin
                    if (imem_rsp_valid_i) state_q <= IDLE;
                    if (redirect_valid_i) pc_q <= redirect_pc_i;
                end
                default: state_q <= IDLE;
            endcase
            if (redirect_valid_i) buf_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (redirect_valid_i) redir_pc_q <= redirect_pc_i;
        if (state_q == WAIT_RSP && imem_rsp_valid_i) begin
            buf_q.instr <= imem_rsp_instr_i;
            buf_q.pc    <= pc_q;
        end
    end

endmodule : fetch_unit

// File: src/decode_unit.sv
`timescale 1ns/1ps

module decode_unit (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 pkt_valid_i,
    output logic                 pkt_ready_o,
    input  core_pkg::fetch_pkt_t pkt_i,
    output logic                 uop_valid_o,
    input  logic                 uop_ready_i,
    output core_pkg::uop_t       uop_o,
    input  logic                 flush_i
);
    import core_pkg::*;

    instr_t  instr;
    opcode_t op;
    uop_t    dec;
    uop_t    uop_q;
    logic    uop_valid_q;

    assign instr = pkt_i.instr;
    assign op    = opcode_t'(instr[15:12]);

    always_comb begin
        dec.op    = op;
        dec.pc    = pkt_i.pc;
        dec.rd    = instr[11:9];
        dec.rs1   = instr[8:6];
        dec.rs2   = instr[5:3];
        dec.imm   = {{10{instr[5]}}, instr[5:0]};
        dec.wr_en = 1'b0;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LW: begin
                dec.wr_en = 1'b1;
            end
            OP_LUI: begin
                dec.imm   = {instr[8:0], 7'b0};
                dec.wr_en = 1'b1;
            end
            OP_JAL: begin
                dec.imm   = {{7{instr[8]}}, instr[8:0]};
                dec.wr_en = 1'b1;
            end
            OP_SW: begin
                dec.rs2 = instr[11:9]; // store data goes out on the second port.
            end
            OP_BEQ, OP_BNE: begin
                dec.rs1 = instr[11:9];
                dec.rs2 = instr[8:6];
            end
            default: begin
                dec.wr_en = 1'b0; // halt and unknown codes write nothing.
            end
        endcase
    end

    // register loads when empty or when execute takes it.
    assign pkt_ready_o = !uop_valid_q || uop_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            uop_valid_q <= 1'b0;
        end else if (flush_i) begin
            uop_valid_q <= 1'b0;
        end else if (pkt_ready_o) begin
            uop_valid_q <= pkt_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pkt_valid_i && pkt_ready_o) uop_q <= dec;
    end

    assign uop_valid_o = uop_valid_q;
    assign uop_o       = uop_q;

endmodule : decode_unit

// File: src/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                uop_valid_i,
    output logic                uop_ready_o,
    input  core_pkg::uop_t      uop_i,
    output logic                dmem_req_valid_o,
    input  logic                dmem_req_ready_i,
    output core_pkg::dmem_req_t dmem_req_o,
    input  logic                dmem_rsp_valid_i,
    input  core_pkg::word_t     dmem_rsp_data_i,
    output logic                redirect_valid_o,
    output core_pkg::word_t     redirect_pc_o,
    output logic                halted_o
);
    import core_pkg::*;

    exec_state_t state_q;
    word_t       rs1_val;
    word_t       rs2_val;
    word_t       alu_res;
    word_t       next_pc;
    word_t       mem_addr;
    word_t       wr_data;
    logic        take;
    logic        is_load;
    logic        is_store;
    logic        complete;
    logic        wr_en;

    register_file u_register_file (
        .clk_i      ( clk_i     ),
        .rst_n_i    ( rst_n_i   ),
        .rs1_idx_i  ( uop_i.rs1 ),
        .rs2_idx_i  ( uop_i.rs2 ),
        .rs1_data_o ( rs1_val   ),
        .rs2_data_o ( rs2_val   ),
        .wr_en_i    ( wr_en     ),
        .wr_idx_i   ( uop_i.rd  ),
        .wr_data_i  ( wr_data   )
    );

    assign next_pc  = uop_i.pc + 16'd1;
    assign mem_addr = rs1_val + uop_i.imm;
    assign is_load  = (uop_i.op == OP_LW);
    assign is_store = (uop_i.op == OP_SW);

    always_comb begin
        alu_res = '0;
        take    = 1'b0;
        case (uop_i.op)
            OP_ADD:  alu_res = rs1_val + rs2_val;
            OP_SUB:  alu_res = rs1_val - rs2_val;
            OP_AND:  alu_res = rs1_val & rs2_val;
            OP_OR:   alu_res = rs1_val | rs2_val;
            OP_XOR:  alu_res = rs1_val ^ rs2_val;
            OP_ADDI: alu_res = rs1_val + uop_i.imm;
            OP_LUI:  alu_res = uop_i.imm;
            OP_BEQ:  take = (rs1_val == rs2_val);
            OP_BNE:  take = (rs1_val != rs2_val);
            OP_JAL: begin
                alu_res = next_pc; // link value.
                take    = 1'b1;
            end
            default: alu_res = '0;
        endcase
    end

    // the uop stays in the decode register until completion, so the request holds.
    assign dmem_req_valid_o = (state_q == RUN) && uop_valid_i && (is_load || is_store);
    assign dmem_req_o.write = is_store;
    assign dmem_req_o.addr  = mem_addr;
    assign dmem_req_o.wdata = rs2_val;

    always_comb begin
        case (state_q)
            RUN:       uop_ready_o = is_store ? dmem_req_ready_i : !is_load;
            WAIT_LOAD: uop_ready_o = dmem_rsp_valid_i;
            default:   uop_ready_o = 1'b0;
        endcase
    end

    assign complete = uop_valid_i && uop_ready_o;
    assign wr_en    = complete && uop_i.wr_en;
    assign wr_data  = is_load ? dmem_rsp_data_i : alu_res;

    // taken branch or jump flushes the younger instructions.
    assign redirect_valid_o = complete && take;
    assign redirect_pc_o    = next_pc + uop_i.imm;
    assign halted_o         = (state_q == HALTED);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= RUN;
        end else begin
            case (state_q)
                RUN: begin
                    if (uop_valid_i && uop_i.op == OP_HALT) begin
                        state_q <= HALTED;
                    end else if (uop_valid_i && is_load && dmem_req_ready_i) begin
                        state_q <= WAIT_LOAD;
                    end
                end
                WAIT_LOAD: begin
                    if (dmem_rsp_valid_i) state_q <= RUN;
                end
                HALTED:  state_q <= HALTED; // only reset leaves.
                default: state_q <= RUN;
            endcase
        end
    end

endmodule : execute_unit

// File: src/mini_core.sv
`timescale 1ns/1ps

module mini_core (
    input  logic                clk_i,
    input  logic                rst_n_i,
    output logic                imem_req_valid_o,
    input  logic                imem_req_ready_i,
    output core_pkg::word_t     imem_req_addr_o,
    input  logic                imem_rsp_valid_i,
    input  core_pkg::instr_t    imem_rsp_instr_i,
    output logic                dmem_req_valid_o,
    input  logic                dmem_req_ready_i,
    output core_pkg::dmem_req_t dmem_req_o,
    input  logic                dmem_rsp_valid_i,
    input  core_pkg::word_t     dmem_rsp_data_i,
    output logic                halted_o
);
    import core_pkg::*;

    logic       pkt_valid;
    logic       pkt_ready;
    fetch_pkt_t pkt;
    logic       uop_valid;
    logic       uop_ready;
    uop_t       uop;
    logic       redirect_valid;
    word_t      redirect_pc;
    logic       halted;

    fetch_unit u_fetch_unit (
        .clk_i            ( clk_i            ),
        .rst_n_i          ( rst_n_i          ),
        .imem_req_valid_o ( imem_req_valid_o ),
        .imem_req_ready_i ( imem_req_ready_i ),
        .imem_req_addr_o  ( imem_req_addr_o  ),
        .imem_rsp_valid_i ( imem_rsp_valid_i ),
        .imem_rsp_instr_i ( imem_rsp_instr_i ),
        .pkt_valid_o      ( pkt_valid        ),
        .pkt_ready_i      ( pkt_ready        ),
        .pkt_o            ( pkt              ),
        .redirect_valid_i ( redirect_valid   ),
        .redirect_pc_i    ( redirect_pc      ),
        .halted_i         ( halted           )
    );

    decode_unit u_decode_unit (
        .clk_i       ( clk_i          ),
        .rst_n_i     ( rst_n_i        ),
        .pkt_valid_i ( pkt_valid      ),
        .pkt_ready_o ( pkt_ready      ),
        .pkt_i       ( pkt            ),
        .uop_valid_o ( uop_valid      ),
        .uop_ready_i ( uop_ready      ),
        .uop_o       ( uop            ),
        .flush_i     ( redirect_valid ) // same pulse that redirects fetch.
    );

    execute_unit u_execute_unit (
        .clk_i            ( clk_i            ),
        .rst_n_i          ( rst_n_i          ),
        .uop_valid_i      ( uop_valid        ),
        .uop_ready_o      ( uop_ready        ),
        .uop_i            ( uop              ),
        .dmem_req_valid_o ( dmem_req_valid_o ),
        .dmem_req_ready_i ( dmem_req_ready_i ),
        .dmem_req_o       ( dmem_req_o       ),
        .dmem_rsp_valid_i ( dmem_rsp_valid_i ),
        .dmem_rsp_data_i  ( dmem_rsp_data_i  ),
        .redirect_valid_o ( redirect_valid   ),
        .redirect_pc_o    ( redirect_pc      ),
        .halted_o         ( halted           )
    );

    assign halted_o = halted;

endmodule : mini_core

// File: verif/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    input  logic rst_req_i,
    output logic clk_o,
    output logic rst_n_o
);
    int rst_cnt;

    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        rst_cnt = 8;
    end

    always #50 clk_o = ~clk_o; // 100 ns period.

    // reset holds for 8 rising edges, again after each request.
    always @(posedge clk_o) begin
        if (rst_req_i) begin
            rst_cnt <= 8;
            rst_n_o <= 1'b0;
        end else if (rst_cnt > 1) begin
            rst_cnt <= rst_cnt - 1;
        end else begin
            rst_cnt <= 0;
            rst_n_o <= 1'b1;
        end
    end

endmodule : clock_gen

// File: verif/mini_core_tb.sv
`timescale 1ns/1ps

module mini_core_tb;
    import core_pkg::*;

    localparam logic [31:0] SEED = 32'h28a8;
    localparam int MEM_WORDS = 256;
    localparam int MAX_STEPS = 4000;

    logic      clk;
    logic      rst_n;
    logic      rst_req = 1'b0;
    logic      imem_req_valid;
    logic      imem_req_ready;
    word_t     imem_req_addr;
    logic      imem_rsp_valid;
    instr_t    imem_rsp_instr;
    logic      dmem_req_valid;
    logic      dmem_req_ready;
    dmem_req_t dmem_req;
    logic      dmem_rsp_valid;
    word_t     dmem_rsp_data;
    logic      halted;

    instr_t      imem [MEM_WORDS];
    word_t       dmem [MEM_WORDS];
    word_t       dmem_init [MEM_WORDS];
    word_t       exp_addr [$];
    word_t       exp_data [$];
    logic [31:0] prog_rng = SEED;
    logic [31:0] imem_rng = SEED ^ 32'h1357;
    logic [31:0] dmem_rng = SEED ^ 32'h2468;
    int          prog_len;
    int          st_idx = 0;
    int          cycle = 0;
    int          deadline = 1000;
    logic        rst_prev_low = 1'b0;
    logic        first_fetch = 1'b1;

    clock_gen u_clock_gen (.rst_req_i(rst_req), .clk_o(clk), .rst_n_o(rst_n));

    mini_core u_mini_core (
        .clk_i            ( clk            ),
        .rst_n_i          ( rst_n          ),
        .imem_req_valid_o ( imem_req_valid ),
        .imem_req_ready_i ( imem_req_ready ),
        .imem_req_addr_o  ( imem_req_addr  ),
        .imem_rsp_valid_i ( imem_rsp_valid ),
        .imem_rsp_instr_i ( imem_rsp_instr ),
        .dmem_req_valid_o ( dmem_req_valid ),
        .dmem_req_ready_i ( dmem_req_ready ),
        .dmem_req_o       ( dmem_req       ),
        .dmem_rsp_valid_i ( dmem_rsp_valid ),
        .dmem_rsp_data_i  ( dmem_rsp_data  ),
        .halted_o         ( halted         )
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic instr_t enc_r(opcode_t op, reg_idx_t a, reg_idx_t b, reg_idx_t c);
        return {op, a, b, c, 3'b000};
    endfunction

    function automatic instr_t enc_i(opcode_t op, reg_idx_t a, reg_idx_t b, logic [5:0] imm);
        return {op, a, b, imm};
    endfunction

    function automatic instr_t enc_u(opcode_t op, reg_idx_t a, logic [8:0] imm);
        return {op, a, imm};
    endfunction

    task automatic stop_with_failure();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic emit(input instr_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    // instruction-level model, fills the expected store list.
    function automatic int run_reference();
        word_t    r [NUM_REGS];
        word_t    m [MEM_WORDS];
        word_t    pc;
        word_t    nxt;
        word_t    s6;
        word_t    ea;
        word_t    res;
        instr_t   ins;
        reg_idx_t a;
        reg_idx_t b;
        reg_idx_t c;
        logic     wr;
        int       steps;
        for (int i = 0; i < MEM_WORDS; i++) m[i] = dmem_init[i];
        for (int i = 0; i < NUM_REGS; i++) r[i] = '0;
        exp_addr.delete();
        exp_data.delete();
        pc = RESET_PC;
        steps = 0;
        while (steps < MAX_STEPS) begin
            ins = imem[pc[7:0]];
            a   = ins[11:9];
            b   = ins[8:6];
            c   = ins[5:3];
            s6  = {{10{ins[5]}}, ins[5:0]};
            nxt = pc + 16'd1;
            ea  = r[b] + s6;
            wr  = 1'b1;
            res = '0;
            steps++;
            case (opcode_t'(ins[15:12]))
                OP_ADD:  res = r[b] + r[c];
                OP_SUB:  res = r[b] - r[c];
                OP_AND:  res = r[b] & r[c];
                OP_OR:   res = r[b] | r[c];
                OP_XOR:  res = r[b] ^ r[c];
                OP_ADDI: res = r[b] + s6;
                OP_LUI:  res = {ins[8:0], 7'd0};
                OP_LW:   res = m[ea[7:0]];
                OP_SW: begin
                    m[ea[7:0]] = r[a];
                    exp_addr.push_back(ea);
                    exp_data.push_back(r[a]);
                    wr = 1'b0;
                end
                OP_BEQ: begin
                    if (r[a] == r[b]) nxt = nxt + s6;
                    wr = 1'b0;
                end
                OP_BNE: begin
                    if (r[a] != r[b]) nxt = nxt + s6;
                    wr = 1'b0;
                end
                OP_JAL: begin
                    res = nxt; // link is the following address.
                    nxt = nxt + {{7{ins[8]}}, ins[8:0]};
                end
                OP_HALT: return steps;
                default: wr = 1'b0;
            endcase
            if (wr && a != 3'd0) r[a] = res;
            pc = nxt;
        end
        return steps;
    endfunction

    task automatic init_memories();
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i]      = {OP_HALT, 4'd0, 8'(i)}; // halt with the address in spare bits.
            prog_rng     = xorshift(prog_rng);
            dmem_init[i] = prog_rng[15:0];
        end
        prog_len = 0;
    endtask

    task automatic build_directed();
        emit(enc_i(OP_ADDI, 3'd1, 3'd0, 6'd5));
        emit(enc_i(OP_ADDI, 3'd2, 3'd0, 6'h3d)); // -3.
        emit(enc_r(OP_ADD, 3'd3, 3'd1, 3'd2));
        emit(enc_r(OP_SUB, 3'd4, 3'd1, 3'd2));
        emit(enc_r(OP_AND, 3'd5, 3'd1, 3'd2));
        emit(enc_r(OP_OR, 3'd6, 3'd1, 3'd2));
        emit(enc_r(OP_XOR, 3'd7, 3'd1, 3'd2));
        for (int i = 3; i < 8; i++) emit(enc_i(OP_SW, 3'(i), 3'd0, 6'(i)));
        emit(enc_u(OP_LUI, 3'd1, 9'h1a5));
        emit(enc_r(OP_ADD, 3'd0, 3'd1, 3'd1)); // r0 must stay zero.
        emit(enc_i(OP_SW, 3'd1, 3'd0, 6'd8));
        emit(enc_i(OP_SW, 3'd0, 3'd0, 6'd9));
        emit(enc_i(OP_LW, 3'd2, 3'd0, 6'd20));
        emit(enc_i(OP_ADDI, 3'd3, 3'd2, 6'd1)); // uses the load right away.
        emit(enc_i(OP_SW, 3'd3, 3'd0, 6'd10));
        emit(enc_i(OP_BEQ, 3'd2, 3'd2, 6'd1));
        emit(enc_i(OP_SW, 3'd1, 3'd0, 6'd11));
        emit(enc_i(OP_BNE, 3'd2, 3'd2, 6'd1));
        emit(enc_i(OP_SW, 3'd2, 3'd0, 6'd12));
        emit(enc_i(OP_BNE, 3'd1, 3'd0, 6'd1));
        emit(enc_i(OP_SW, 3'd1, 3'd0, 6'd13));
        emit(enc_i(OP_BEQ, 3'd1, 3'd0, 6'd1));
        emit(enc_i(OP_SW, 3'd2, 3'd1, 6'h3e)); // negative offset.
        emit(enc_u(OP_JAL, 3'd4, 9'd2));
        emit(enc_i(OP_SW, 3'd1, 3'd0, 6'd15));
        emit(enc_i(OP_SW, 3'd1, 3'd0, 6'd16));
        emit(enc_i(OP_SW, 3'd4, 3'd0, 6'd17));
        emit(enc_i(OP_ADDI, 3'd6, 3'd0, 6'd3));
        emit(enc_i(OP_ADDI, 3'd6, 3'd6, 6'h3f));
        emit(enc_i(OP_SW, 3'd6, 3'd0, 6'd18));
        emit(enc_i(OP_BNE, 3'd6, 3'd0, 6'h3d)); // loop body runs three times.
        emit(enc_u(OP_HALT, 3'd0, 9'd0));
    endtask

    task automatic build_random();
        logic [31:0] v;
        for (int i = 0; i < 40; i++) begin
            prog_rng = xorshift(prog_rng);
            v = prog_rng;
            case (v[3:0])
                4'd5: emit(enc_i(OP_ADDI, v[6:4], v[9:7], v[15:10]));
                4'd6: emit(enc_u(OP_LUI, v[6:4], v[18:10]));
                4'd7, 4'd8, 4'd9: emit(enc_i(OP_LW, v[6:4], 3'd0, {1'b0, v[14:10]}));
                default: begin
                    if (v[3:0] < 4'd5) emit(enc_r(opcode_t'(v[3:0]), v[6:4], v[9:7], v[12:10]));
                    else emit(enc_i(OP_SW, v[6:4], v[9:7], {1'b0, v[14:10]}));
                end
            endcase
        end
        for (int i = 1; i < NUM_REGS; i++) emit(enc_i(OP_SW, 3'(i), 3'd0, 6'(16 + i)));
        emit(enc_u(OP_HALT, 3'd0, 9'd0));
    endtask

    task automatic run_program(input string name);
        int steps;
        steps = run_reference();
        for (int i = 0; i < MEM_WORDS; i++) dmem[i] = dmem_init[i];
        deadline = cycle + 40 * steps + 60;
        @(posedge clk);
        #1 rst_req = 1'b1;
        @(posedge clk);
        #1 rst_req = 1'b0;
        do @(negedge clk); while (!(rst_n && halted));
        assert (st_idx == exp_addr.size()) else begin
            $display("core halted after %0d stores, %0d expected", st_idx, exp_addr.size());
            stop_with_failure();
        end
        repeat (20) @(negedge clk); // core must stay quiet.
        $display("%s program: %0d instructions, %0d stores", name, steps, st_idx);
    endtask

    initial begin : imem_model
        logic  fire;
        logic  pend;
        logic  rst_s;
        word_t addr;
        word_t paddr;
        int    cnt;
        imem_req_ready = 1'b0;
        imem_rsp_valid = 1'b0;
        imem_rsp_instr = '0;
        pend = 1'b0;
        paddr = '0;
        cnt = 0;
        forever begin
            @(negedge clk);
            fire  = imem_req_valid && imem_req_ready;
            addr  = imem_req_addr;
            rst_s = rst_n;
            @(posedge clk);
            #1;
            imem_rsp_valid = 1'b0;
            imem_rng = xorshift(imem_rng);
            imem_req_ready = rst_s && (imem_rng[1:0] != 2'b00);
            if (!rst_s) begin
                pend = 1'b0;
            end else if (fire) begin
                pend  = 1'b1;
                paddr = addr;
                cnt   = int'(imem_rng[3:2]); // one to four cycles.
            end
            if (pend) begin
                if (cnt == 0) begin
                    imem_rsp_valid = 1'b1;
                    imem_rsp_instr = imem[paddr[7:0]];
                    pend = 1'b0;
                end else begin
                    cnt--;
                end
            end
        end
    end

    initial begin : dmem_model
        logic      fire;
        logic      pend;
        logic      rst_s;
        dmem_req_t req;
        word_t     rdata;
        int        cnt;
        dmem_req_ready = 1'b0;
        dmem_rsp_valid = 1'b0;
        dmem_rsp_data = '0;
        pend = 1'b0;
        rdata = '0;
        cnt = 0;
        forever begin
            @(negedge clk);
            fire  = dmem_req_valid && dmem_req_ready;
            req   = dmem_req;
            rst_s = rst_n;
            @(posedge clk);
            #1;
            dmem_rsp_valid = 1'b0;
            dmem_rng = xorshift(dmem_rng);
            dmem_req_ready = rst_s && (dmem_rng[1:0] != 2'b00);
            if (!rst_s) begin
                pend = 1'b0;
            end else if (fire && req.write) begin
                dmem[req.addr[7:0]] = req.wdata;
            end else if (fire) begin
                pend  = 1'b1;
                rdata = dmem[req.addr[7:0]];
                cnt   = int'(dmem_rng[3:2]);
            end
            if (pend) begin
                if (cnt == 0) begin
                    dmem_rsp_valid = 1'b1;
                    dmem_rsp_data = rdata;
                    pend = 1'b0;
                end else begin
                    cnt--;
                end
            end
        end
    end

    // stores are compared in order against the reference list.
    always @(negedge clk) begin
        if (!rst_n) begin
            st_idx = 0;
        end else if (dmem_req_valid && dmem_req_ready && dmem_req.write) begin
            assert (st_idx < exp_addr.size()) else begin
                $display("store number %0d was not expected", st_idx);
                stop_with_failure();
            end
            assert (dmem_req.addr == exp_addr[st_idx]) else begin
                $display("** Error: dmem_req_o.addr expected 0x%h, got 0x%h",
                         exp_addr[st_idx], dmem_req.addr);
                stop_with_failure();
            end
            assert (dmem_req.wdata == exp_data[st_idx]) else begin
                $display("** Error: dmem_req_o.wdata expected 0x%h, got 0x%h",
                         exp_data[st_idx], dmem_req.wdata);
                stop_with_failure();
            end
            st_idx++;
        end
    end

    always @(negedge clk) begin
        if (!rst_n) begin
            if (rst_prev_low) begin
                assert (!imem_req_valid && !dmem_req_valid && !halted) else begin
                    $display("request or halt active during reset");
                    stop_with_failure();
                end
            end
            rst_prev_low = 1'b1;
            first_fetch  = 1'b1;
        end else begin
            rst_prev_low = 1'b0;
            if (first_fetch && imem_req_valid && imem_req_ready) begin
                assert (imem_req_addr == RESET_PC) else begin
                    $display("** Error: imem_req_addr_o expected 0x%h, got 0x%h",
                             RESET_PC, imem_req_addr);
                    stop_with_failure();
                end
                first_fetch = 1'b0;
            end
            if (halted) begin
                assert (!imem_req_valid && !dmem_req_valid) else begin
                    $display("a request was issued after the core halted");
                    stop_with_failure();
                end
            end
        end
    end

    always @(negedge clk) begin
        cycle++;
        if (cycle > deadline) begin
            $display("timeout: core did not halt by cycle %0d", deadline);
            stop_with_failure();
        end
    end

    initial begin
        init_memories();
        build_directed();
        run_program("directed");
        init_memories();
        build_random();
        run_program("random");
        $display("Test completed successfully");
        $finish;
    end

endmodule : mini_core_tb

// File: files.f
src/core_pkg.sv
src/register_file.sv
src/fetch_unit.sv
src/decode_unit.sv
src/execute_unit.sv
src/mini_core.sv
verif/clock_gen.sv
verif/mini_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mini_core_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
